// ==== cacheCtrl/cacheCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl
   import memSysPkg::*;
(
   input  logic             clk,
   input  logic             rstN,
   input  addrU             addr,
   input  logic [wordW-1:0] dataIn,
   input  logic             rd,
   input  logic             wr,
   input  wayRspT           rsp0,
   input  wayRspT           rsp1,
   input  logic [wordW-1:0] memData,
   output wayReqT           req0,
   output wayReqT           req1,
   output memReqT           memReq,
   output logic [wordW-1:0] dataOut,
   output logic             done,
   output logic             stall,
   output logic             cacheHit
);

   ctrlStateT             state;
   ctrlStateT             nextState;
   logic [wordSelW-1:0]   wordCnt;    // issue side, writeback and fetch
   logic [wordSelW-1:0]   fillCnt;    // return side of the fetch
   logic [wordSelW-1:0]   reqWord;
   logic [memLatency-1:0] rdPend;
   logic                  victimBit;
   logic                  victimSel;
   logic                  wayLat;
   logic                  useWay;
   logic                  anyHit;
   logic                  fillWe;
   logic [wordW-1:0]      hitData;
   wayRspT                vicRsp;
   wayReqT                wReq;

   assign reqWord = addr.f.offset[offsetW-1:1];
   assign anyHit  = rsp0.hit | rsp1.hit;
   assign hitData = rsp0.hit ? rsp0.data : rsp1.data;
   assign fillWe  = rdPend[memLatency-1];    // fetched word on memData now

   // invalid way first, way 0 before way 1
   assign victimSel = ~rsp0.valid ? 1'b0 : (~rsp1.valid ? 1'b1 : victimBit);
   assign useWay    = (state == compare) ? victimSel : wayLat;
   assign vicRsp    = useWay ? rsp1 : rsp0;

   always_comb begin
      nextState  = state;
      wReq       = '0;
      wReq.index = addr.f.index;
      wReq.tag   = addr.f.tag;
      wReq.word  = reqWord;
      wReq.data  = dataIn;
      memReq     = '0;
      case (state)
         idle: begin
            if (rd || wr) begin
               nextState = compare;
            end
         end
         compare: begin
            wReq.en    = 1'b1;
            wReq.comp  = 1'b1;
            wReq.write = wr;
            if (anyHit) begin
               nextState = idle;
            end else if (vicRsp.valid && vicRsp.dirty) begin
               nextState = writeBack;
            end else if (wr) begin
               nextState = writeThrough;
            end else begin
               nextState = fetch;
            end
         end
         writeBack: begin
            wReq.en     = 1'b1;
            wReq.word   = wordCnt;
            memReq.wr   = 1'b1;
            memReq.addr = {vicRsp.tag, addr.f.index, wordCnt};    // old line address
            memReq.data = vicRsp.data;
            if (wordCnt == lastWord) begin
               nextState = wr ? writeThrough : fetch;
            end
         end
         writeThrough: begin
            memReq.wr   = 1'b1;
            memReq.addr = {addr.f.tag, addr.f.index, reqWord};
            memReq.data = dataIn;
            nextState   = fetch;
         end
         fetch: begin
            memReq.rd   = 1'b1;
            memReq.addr = {addr.f.tag, addr.f.index, wordCnt};
            if (wordCnt == lastWord) begin
               nextState = fill;
            end
         end
         fill: begin
            if (fillWe && fillCnt == lastWord) begin
               nextState = finish;
            end
         end
         finish: begin
            wReq.en       = 1'b1;
            wReq.setValid = 1'b1;
            nextState     = idle;
         end
         default: nextState = idle;
      endcase
      // returning words overlap the last fetch issues
      if (fillWe) begin
         wReq.en    = 1'b1;
         wReq.write = 1'b1;
         wReq.word  = fillCnt;
         wReq.data  = memData;
      end
   end

   // compare looks at both ways, everything else only at the victim
   always_comb begin
      req0    = wReq;
      req1    = wReq;
      req0.en = wReq.en & ((state == compare) | ~useWay);
      req1.en = wReq.en & ((state == compare) | useWay);
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state     <= idle;
         wordCnt   <= '0;
         fillCnt   <= '0;
         rdPend    <= '0;
         victimBit <= 1'b0;
         wayLat    <= 1'b0;
         done      <= 1'b0;
         stall     <= 1'b0;
         cacheHit  <= 1'b0;
      end else begin
         state  <= nextState;
         rdPend <= {rdPend[memLatency-2:0], memReq.rd};
         done   <= (state != idle) && (nextState == idle);
         if (state == idle && (rd || wr)) begin
            victimBit <= ~victimBit;
            stall     <= 1'b1;
         end else if (nextState == idle) begin
            stall <= 1'b0;
         end
         if (state == compare) begin
            wayLat   <= victimSel;
            cacheHit <= anyHit;
         end
         if (state == writeBack || state == fetch) begin
            wordCnt <= wordCnt + 1'b1;    // wraps back to 0 after four
         end
         if (fillWe) begin
            fillCnt <= fillCnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == compare && anyHit) begin
         dataOut <= hitData;
      end else if (fillWe && rd && fillCnt == reqWord) begin
         dataOut <= memData;    // requested word as it comes back
      end
   end

endmodule

`default_nettype wire

// ==== common/memSysPkg.sv ====
`default_nettype none

package memSysPkg;

   localparam int wordW      = 16;
   localparam int tagW       = 5;
   localparam int indexW     = 8;
   localparam int offsetW    = 3;    // byte offset within a line
   localparam int lineWords  = 4;
   localparam int memLatency = 2;    // read request to data, in cycles
   localparam int memWords   = 32768;

   localparam int numSets  = 1 << indexW;
   localparam int wordSelW = $clog2(lineWords);
   localparam int memAddrW = $clog2(memWords);    // word address into main memory

   localparam logic [wordSelW-1:0] lastWord = wordSelW'(lineWords - 1);

   typedef struct packed {
      logic [tagW-1:0]    tag;
      logic [indexW-1:0]  index;
      logic [offsetW-1:0] offset;
   } addrFieldsT;

   // same 16 bits, seen whole or split for the cache lookup
   typedef union packed {
      logic [wordW-1:0] flat;
      addrFieldsT       f;
   } addrU;

   typedef struct packed {
      logic                en;
      logic                comp;       // tag compare, write only on hit
      logic                write;
      logic                setValid;   // load tag, set valid, clear dirty
      logic [indexW-1:0]   index;
      logic [tagW-1:0]     tag;
      logic [wordSelW-1:0] word;
      logic [wordW-1:0]    data;
   } wayReqT;

   typedef struct packed {
      logic             hit;
      logic             valid;
      logic             dirty;
      logic [tagW-1:0]  tag;
      logic [wordW-1:0] data;
   } wayRspT;

   typedef struct packed {
      logic                rd;
      logic                wr;
      logic [memAddrW-1:0] addr;
      logic [wordW-1:0]    data;
   } memReqT;

   typedef enum logic [2:0] {
      idle,
      compare,
      writeBack,
      writeThrough,
      fetch,
      fill,
      finish
   } ctrlStateT;

endpackage

`default_nettype wire

// ==== memSystem.f ====
common/memSysPkg.sv
src/cacheWay.sv
src/mainMem.sv
cacheCtrl/cacheCtrl.sv
src/memSystem.sv
tb/tbClock.sv
tb/memSystem_chk.sv
tb/memSystemTb.sv

// ==== src/cacheWay.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheWay
   import memSysPkg::*;
(
   input  logic   clk,
   input  logic   rstN,
   input  wayReqT req,
   output wayRspT rsp
);

   logic [tagW-1:0]            tagMem  [numSets];
   logic [wordW-1:0]           dataMem [numSets*lineWords];
   logic [numSets-1:0]         validBits;
   logic [numSets-1:0]         dirtyBits;
   logic [indexW+wordSelW-1:0] wordIdx;
   logic                       tagMatch;
   logic                       dataWe;

   assign wordIdx  = {req.index, req.word};
   assign tagMatch = (tagMem[req.index] == req.tag);

   always_comb begin
      rsp.valid = validBits[req.index];
      rsp.dirty = dirtyBits[req.index];
      rsp.tag   = tagMem[req.index];
      rsp.data  = dataMem[wordIdx];
      rsp.hit   = req.en & validBits[req.index] & tagMatch;
   end

   // a compare-write lands only on a hit
   assign dataWe = req.en & req.write & (~req.comp | rsp.hit);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         validBits <= '0;
         dirtyBits <= '0;
      end else begin
         if (dataWe && req.comp) begin
            dirtyBits[req.index] <= 1'b1;
         end
         if (req.en && req.setValid) begin
            validBits[req.index] <= 1'b1;
            dirtyBits[req.index] <= 1'b0;    // freshly filled line
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req.en && req.setValid) begin
         tagMem[req.index] <= req.tag;
      end
   end

   always_ff @(posedge clk) begin
      if (dataWe) begin
         dataMem[wordIdx] <= req.data;
      end
   end

endmodule

`default_nettype wire

// ==== src/mainMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mainMem
   import memSysPkg::*;
(
   input  logic             clk,
   input  logic             rstN,
   input  memReqT           req,
   output logic [wordW-1:0] memData
);

   logic [wordW-1:0] memArray [memWords];
   logic [wordW-1:0] rdStage  [memLatency];

   // preset image, every word holds its own byte address
   initial begin
      for (int i = 0; i < memWords; i++) begin
         memArray[i] = wordW'(i * 2);
      end
   end

   always @(posedge clk) begin
      if (req.wr) begin
         memArray[req.addr] <= req.data;
      end
   end

   // read pipeline, one stage per cycle of latency
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int s = 0; s < memLatency; s++) begin
            rdStage[s] <= '0;
         end
      end else begin
         rdStage[0] <= req.rd ? memArray[req.addr] : '0;    // old data on same-cycle write
         for (int s = 1; s < memLatency; s++) begin
            rdStage[s] <= rdStage[s-1];
         end
      end
   end

   assign memData = rdStage[memLatency-1];

endmodule

`default_nettype wire

// ==== src/memSystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSystem
   import memSysPkg::*;
(
   input  logic             clk,
   input  logic             rstN,
   input  addrU             addr,
   input  logic [wordW-1:0] dataIn,
   input  logic             rd,
   input  logic             wr,
   output logic [wordW-1:0] dataOut,
   output logic             done,
   output logic             stall,
   output logic             cacheHit
);

   wayReqT           req0;
   wayReqT           req1;
   wayRspT           rsp0;
   wayRspT           rsp1;
   memReqT           memReq;
   logic [wordW-1:0] memData;

   cacheCtrl ctrl0 (
      .clk      (clk),
      .rstN     (rstN),
      .addr     (addr),
      .dataIn   (dataIn),
      .rd       (rd),
      .wr       (wr),
      .rsp0     (rsp0),
      .rsp1     (rsp1),
      .memData  (memData),
      .req0     (req0),
      .req1     (req1),
      .memReq   (memReq),
      .dataOut  (dataOut),
      .done     (done),
      .stall    (stall),
      .cacheHit (cacheHit)
   );

   cacheWay way0 (.clk(clk), .rstN(rstN), .req(req0), .rsp(rsp0));
   cacheWay way1 (.clk(clk), .rstN(rstN), .req(req1), .rsp(rsp1));

   mainMem mem0 (.clk(clk), .rstN(rstN), .req(memReq), .memData(memData));

endmodule

`default_nettype wire

// ==== tb/memSystemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSystemTb
   import memSysPkg::*;
();

   localparam int numDirected = 16;
   localparam int numRandom   = 40;
   localparam int cycleLimit  = 60 * (numDirected + numRandom);

   logic             clk;
   logic             rstN;
   addrU             addr;
   logic [wordW-1:0] dataIn;
   logic             rd;
   logic             wr;
   logic [wordW-1:0] dataOut;
   logic             done;
   logic             stall;
   logic             cacheHit;

   logic [wordW-1:0] shadow [memWords];    // expected memory contents
   logic [15:0]      lfsr;
   int               dataErrors;
   int               cycleCnt = 0;
   logic [wordW-1:0] gotData;
   logic             gotHit;

   tbClock clkGen (.clk(clk), .rstN(rstN));

   memSystem dut0 (
      .clk      (clk),
      .rstN     (rstN),
      .addr     (addr),
      .dataIn   (dataIn),
      .rd       (rd),
      .wr       (wr),
      .dataOut  (dataOut),
      .done     (done),
      .stall    (stall),
      .cacheHit (cacheHit)
   );

   function automatic logic [wordW-1:0] byteAddr(input logic [tagW-1:0] tag,
                                                 input logic [indexW-1:0] index,
                                                 input logic [1:0] word);
      return {tag, index, word, 1'b0};
   endfunction

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] takeBits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         v    = {v[14:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic checkValue(input string sigName, input logic [wordW-1:0] got,
                             input logic [wordW-1:0] exp);
      assert (got === exp) else begin
         dataErrors++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, sigName, got, exp);
      end
   endtask

   task automatic checkHit(input logic exp);
      checkValue("cacheHit", {15'b0, gotHit}, {15'b0, exp});
   endtask

   task automatic request(input logic isWrite, input logic [wordW-1:0] a,
                          input logic [wordW-1:0] d);
      @(posedge clk);
      #1;
      addr.flat = a;
      dataIn    = d;
      rd        = ~isWrite;
      wr        = isWrite;
      do begin
         @(posedge clk);
         #1;
      end while (!done);
      gotData = dataOut;
      gotHit  = cacheHit;
      rd      = 1'b0;    // released in the done cycle
      wr      = 1'b0;
      if (isWrite) begin
         shadow[a[wordW-1:1]] = d;
      end
   endtask

   task automatic readCheck(input logic [wordW-1:0] a);
      request(1'b0, a, '0);
      checkValue("dataOut", gotData, shadow[a[wordW-1:1]]);
   endtask

   initial begin
      logic [15:0]      v;
      logic [wordW-1:0] a;
      logic             isWr;
      addr.flat  = '0;
      dataIn     = '0;
      rd         = 1'b0;
      wr         = 1'b0;
      lfsr       = 16'd33;
      dataErrors = 0;
      for (int i = 0; i < memWords; i++) begin
         shadow[i] = wordW'(i * 2);    // identity image
      end
      wait (rstN === 1'b1);

      request(1'b0, 16'h1234, '0);    // cold miss
      checkValue("dataOut", gotData, 16'h1234);
      checkHit(1'b0);
      readCheck(16'h1236);    // same line
      checkHit(1'b1);
      request(1'b1, 16'h1232, 16'hbeef);
      checkHit(1'b1);
      readCheck(16'h1232);
      checkHit(1'b1);

      // three tags on one index, each line left dirty
      for (int t = 1; t <= 3; t++) begin
         request(1'b1, byteAddr(tagW'(t), 8'h20, 2'd0), wordW'(16'ha000 + t));
         request(1'b1, byteAddr(tagW'(t), 8'h20, 2'd1), wordW'(16'hb000 + t));
         checkHit(1'b1);
      end
      for (int t = 1; t <= 3; t++) begin
         readCheck(byteAddr(tagW'(t), 8'h20, 2'd0));
         readCheck(byteAddr(tagW'(t), 8'h20, 2'd1));
      end

      for (int n = 0; n < numRandom; n++) begin
         v    = takeBits(1);
         isWr = v[0];
         v    = takeBits(2);
         a    = {11'b0, v[1:0], 3'b0};    // index 0x40 to 0x43
         v    = takeBits(2);
         a    = byteAddr({3'b000, v[1:0]}, {6'b010000, a[4:3]}, 2'd0);
         v    = takeBits(2);
         a[2:1] = v[1:0];
         if (isWr) begin
            v = takeBits(16);
            request(1'b1, a, v);
         end else begin
            readCheck(a);
         end
      end

      $display("closing: data errors %0d, protocol errors %0d", dataErrors,
               dut0.chk0.failCnt);
      if (dataErrors == 0 && dut0.chk0.failCnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycleCnt++;
      if (cycleCnt >= cycleLimit) begin
         $display("timeout: requests not finished within %0d cycles", cycleLimit);
         $display("closing: data errors %0d, protocol errors %0d", dataErrors,
                  dut0.chk0.failCnt);
         $display("Test failed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== tb/memSystem_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSystemChk (
   input logic clk,
   input logic rstN,
   input logic rd,
   input logic wr,
   input logic done,
   input logic stall,
   input logic cacheHit,
   input logic hit0,
   input logic hit1
);

   int failCnt = 0;

   property resetClear;
      @(posedge clk) !rstN |=> (!stall && !done);
   endproperty

   property donePulse;
      @(posedge clk) disable iff (!rstN) done |=> !done;
   endproperty

   property noStallAtDone;
      @(posedge clk) disable iff (!rstN) done |-> !stall;
   endproperty

   property stallBeforeDone;
      @(posedge clk) disable iff (!rstN) done |-> $past(stall);
   endproperty

   // request edge, compare cycle, then done
   property hitTiming;
      @(posedge clk) disable iff (!rstN)
         ((rd || wr) && !stall) ##1 (hit0 || hit1) |=> (done && cacheHit);
   endproperty

   property hitOnlyWhenFast;
      @(posedge clk) disable iff (!rstN)
         (done && cacheHit) |-> $past((rd || wr) && !stall, 2);
   endproperty

   assert property (resetClear) else begin
      failCnt++;
      $error("stall or done not low after reset");
   end
   assert property (donePulse) else begin
      failCnt++;
      $error("done stayed high for more than one cycle");
   end
   assert property (noStallAtDone) else begin
      failCnt++;
      $error("stall high while done is high");
   end
   assert property (stallBeforeDone) else begin
      failCnt++;
      $error("done without stall in the cycle before");
   end
   assert property (hitTiming) else begin
      failCnt++;
      $error("hit did not finish two cycles after the request");
   end
   assert property (hitOnlyWhenFast) else begin
      failCnt++;
      $error("cacheHit reported on a request that did not finish in two cycles");
   end

endmodule

bind memSystem memSystemChk chk0 (
   .clk      (clk),
   .rstN     (rstN),
   .rd       (rd),
   .wr       (wr),
   .done     (done),
   .stall    (stall),
   .cacheHit (cacheHit),
   .hit0     (rsp0.hit),
   .hit1     (rsp1.hit)
);

`default_nettype wire

// ==== tb/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock (
   output logic clk,
   output logic rstN
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;    // 10 ns period
   end

   initial begin
      rstN = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rstN = 1'b1;
   end

endmodule

`default_nettype wire
